// ==== build.f ====
+incdir+tb
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/reorder_buffer.sv
rtl/rename_stage.sv
tb/rename_stage_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := rename_stage_tb
FILELIST := build.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation finished: PASS

SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard tb/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/rename_stage_tasks.svh ====
// any register but zero
function automatic reg_idx_t pick_reg();
    return reg_idx_t'(1 + $urandom % (REG_COUNT - 1));
endfunction

task automatic tick();
    settle();
    advance();
endtask

task automatic issue(input reg_idx_t rd);
    dispatch_enable = 1'b1;
    dispatch_rd     = rd;
    tick();
endtask

task automatic complete(input tag_t tag);
    cdb_valid = 1'b1;
    cdb_tag   = tag;
    tick();
endtask

// returns mid-cycle in the retire cycle, caller advances
task automatic wait_retire(output reg_idx_t rd, output tag_t tag);
    int waited;
    waited = 0;
    settle();
    while (!retire_valid && waited < 40) begin
        advance();
        settle();
        waited++;
    end
    if (!retire_valid) begin
        $display("ERROR: no retire within 40 cycles at time %0t", $time);
        errors++;
    end
    rd  = retire_reg;
    tag = retire_tag;
endtask

// complete whatever is still pending, then let the buffer empty
task automatic drain();
    tag_t       pending [$];
    rob_entry_t entry;
    int         waited;
    foreach (rob_q[i]) begin
        entry = rob_q[i];
        if (!entry.done) begin
            pending.push_back(entry.tag);
        end
    end
    foreach (pending[i]) begin
        complete(pending[i]);
    end
    waited = 0;
    settle();
    while (retire_valid && waited < 40) begin
        advance();
        settle();
        waited++;
    end
    if (retire_valid || rob_q.size() != 0) begin
        $display("ERROR: buffer did not drain at time %0t", $time);
        errors++;
    end
    advance();
endtask

task automatic check_clear_state();
    for (int i = 0; i < REG_COUNT / 2; i++) begin
        src1_reg = reg_idx_t'(i);
        src2_reg = reg_idx_t'(i + REG_COUNT / 2);
        settle();
        check_word("src1_tag", ZERO_TAG, src1_tag);
        check_word("src2_tag", ZERO_TAG, src2_tag);
        verify_flag("full", 1'b0, full);
        advance();
    end
endtask

////////////////////////////////
// directed tests
////////////////////////////////

task automatic test_rename();
    reg_idx_t ra;
    tag_t     first;
    tag_t     second;
    ra       = pick_reg();
    src1_reg = ra;
    src2_reg = ZERO_REG;
    first    = {1'b0, model_tail};
    dispatch_enable = 1'b1;
    dispatch_rd     = ra;
    settle();
    check_word("dispatch_tag", first, dispatch_tag);
    advance();
    settle();
    check_word("src1_tag", first, src1_tag);
    verify_flag("src1_ready", 1'b0, src1_ready);
    advance();
    // newer producer replaces the mapping
    second = {1'b0, model_tail};
    issue(ra);
    settle();
    check_word("src1_tag", second, src1_tag);
    advance();
    issue(ZERO_REG);
    settle();
    check_word("src2_tag", ZERO_TAG, src2_tag);
    advance();
    drain();
endtask

task automatic test_wakeup();
    reg_idx_t ra;
    reg_idx_t rb;
    tag_t     t_old;
    tag_t     t_b;
    tag_t     t_new;
    ra       = pick_reg();
    rb       = (ra == reg_idx_t'(REG_COUNT - 1)) ? reg_idx_t'(1) : ra + 1'b1;
    src1_reg = ra;
    src2_reg = rb;
    t_old    = {1'b0, model_tail};
    issue(ra);
    t_b      = {1'b0, model_tail};
    issue(rb);
    t_new    = {1'b0, model_tail};
    issue(ra);
    complete(t_b);
    settle();
    verify_flag("src2_ready", 1'b1, src2_ready);
    verify_flag("src1_ready", 1'b0, src1_ready);
    advance();
    // ra moved on to t_new and must stay waiting
    complete(t_old);
    settle();
    check_word("src1_tag", t_new, src1_tag);
    verify_flag("src1_ready", 1'b0, src1_ready);
    advance();
    drain();
endtask

task automatic test_retire();
    reg_idx_t regs [5];
    tag_t     tags [5];
    int       order [5];
    reg_idx_t base;
    reg_idx_t rd;
    tag_t     tag;
    order = '{3, 1, 4, 2, 0};
    base  = reg_idx_t'(1 + $urandom % 24);
    for (int i = 0; i < 4; i++) begin
        regs[i] = base + reg_idx_t'(2 * i);
    end
    regs[4] = regs[1];
    for (int i = 0; i < 5; i++) begin
        tags[i] = {1'b0, model_tail};
        issue(regs[i]);
    end
    src1_reg = regs[0];
    src2_reg = regs[1];
    foreach (order[i]) begin
        complete(tags[order[i]]);
    end
    for (int i = 0; i < 5; i++) begin
        wait_retire(rd, tag);
        check_word("retire_reg", regs[i], rd);
        check_word("retire_tag", tags[i], tag);
        if (i == 0) begin
            // cleared within the retire cycle itself
            check_word("src1_tag", ZERO_TAG, src1_tag);
            verify_flag("src1_ready", 1'b0, src1_ready);
        end
        if (i == 1) begin
            check_word("src2_tag", tags[4], src2_tag);
            verify_flag("src2_ready", 1'b1, src2_ready);
        end
        advance();
    end
endtask

task automatic test_full();
    reg_idx_t rf;
    reg_idx_t rl;
    reg_idx_t rd;
    tag_t     first;
    tag_t     held;
    tag_t     tag;
    rf       = pick_reg();
    src1_reg = rf;
    first    = {1'b0, model_tail};
    issue(rf);
    for (int i = 1; i < ROB_DEPTH; i++) begin
        rl   = pick_reg();
        held = {1'b0, model_tail};
        issue(rl);
    end
    // last register renamed holds a tag other than the tail
    src2_reg = rl;
    settle();
    verify_flag("full", 1'b1, full);
    advance();
    // refused while full
    dispatch_enable = 1'b1;
    dispatch_rd     = rl;
    tick();
    settle();
    check_word("src2_tag", held, src2_tag);
    advance();
    complete(first);
    wait_retire(rd, tag);
    check_word("retire_tag", first, tag);
    advance();
    dispatch_enable = 1'b1;
    dispatch_rd     = rf;
    settle();
    verify_flag("full", 1'b0, full);
    advance();
    settle();
    check_word("src1_tag", first, src1_tag);
    advance();
    drain();
endtask

task automatic test_squash();
    tag_t t1;
    tag_t t2;
    t1 = {1'b0, model_tail};
    issue(pick_reg());
    t2 = {1'b0, model_tail};
    issue(pick_reg());
    complete(t1);
    // retire, completion and dispatch all lose to squash
    squash          = 1'b1;
    cdb_valid       = 1'b1;
    cdb_tag         = t2;
    dispatch_enable = 1'b1;
    dispatch_rd     = pick_reg();
    settle();
    verify_flag("retire_valid", 1'b1, retire_valid);
    advance();
    check_clear_state();
    dispatch_enable = 1'b1;
    dispatch_rd     = pick_reg();
    settle();
    check_word("dispatch_tag", tag_t'(0), dispatch_tag);
    advance();
    drain();
endtask

// ==== tb/rename_stage_tb.sv ====
`timescale 1ns/1ps

module rename_stage_tb;

    import rename_pkg::*;

    // cycles per test: reset, clear state, rename, wakeup, retire, full, squash
    localparam int RUN_CYCLES = 5 + 16 + 15 + 15 + 20 + 60 + 30;
    localparam int MARGIN     = 100;

    typedef struct packed {
        logic     done;
        reg_idx_t rd;
        tag_t     tag;
    } rob_entry_t;

    logic     clock;
    logic     reset;
    logic     dispatch_enable;
    reg_idx_t dispatch_rd;
    reg_idx_t src1_reg;
    reg_idx_t src2_reg;
    logic     cdb_valid;
    tag_t     cdb_tag;
    logic     squash;
    tag_t     dispatch_tag;
    logic     full;
    tag_t     src1_tag;
    logic     src1_ready;
    tag_t     src2_tag;
    logic     src2_ready;
    logic     retire_valid;
    reg_idx_t retire_reg;
    tag_t     retire_tag;

    // reference model of the map and the buffer
    tag_t                 model_tag [REG_COUNT];
    logic [REG_COUNT-1:0] model_ready;
    rob_entry_t           rob_q [$];
    rob_idx_t             model_tail;

    int errors;
    int checks;

    rename_stage u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic check_word(input string name, input tag_t expected, input tag_t actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic verify_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected %0b actual %0b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < REG_COUNT; i++) begin
            model_tag[i] = ZERO_TAG;
        end
        model_ready = '0;
        rob_q.delete();
        model_tail = '0;
    endtask

    // mid-cycle compare of every output against the model
    task automatic settle();
        rob_entry_t head;
        logic       bypass;
        #2;
        head = '0;
        if (rob_q.size() > 0) begin
            head = rob_q[0];
        end
        bypass = head.done && (model_tag[head.rd] == head.tag);
        verify_flag("full", rob_q.size() == ROB_DEPTH, full);
        verify_flag("retire_valid", head.done, retire_valid);
        if (head.done) begin
            check_word("retire_reg", head.rd, retire_reg);
            check_word("retire_tag", head.tag, retire_tag);
        end
        check_word("dispatch_tag", {1'b0, model_tail}, dispatch_tag);
        if (bypass && head.rd == src1_reg) begin
            check_word("src1_tag", ZERO_TAG, src1_tag);
            verify_flag("src1_ready", 1'b0, src1_ready);
        end else begin
            check_word("src1_tag", model_tag[src1_reg], src1_tag);
            verify_flag("src1_ready", model_ready[src1_reg], src1_ready);
        end
        if (bypass && head.rd == src2_reg) begin
            check_word("src2_tag", ZERO_TAG, src2_tag);
            verify_flag("src2_ready", 1'b0, src2_ready);
        end else begin
            check_word("src2_tag", model_tag[src2_reg], src2_tag);
            verify_flag("src2_ready", model_ready[src2_reg], src2_ready);
        end
    endtask

    // edge update: squash, else retire clear, wakeup, then rename
    task automatic update_model();
        rob_entry_t entry;
        logic       accept;
        if (squash) begin
            clear_model();
        end else begin
            accept = dispatch_enable && (rob_q.size() < ROB_DEPTH);
            if (rob_q.size() > 0) begin
                entry = rob_q[0];
                if (entry.done) begin
                    void'(rob_q.pop_front());
                    if (model_tag[entry.rd] == entry.tag) begin
                        model_tag[entry.rd]   = ZERO_TAG;
                        model_ready[entry.rd] = 1'b0;
                    end
                end
            end
            if (cdb_valid) begin
                foreach (rob_q[i]) begin
                    entry = rob_q[i];
                    if (entry.tag == cdb_tag) begin
                        entry.done = 1'b1;
                        rob_q[i]   = entry;
                    end
                end
                for (int i = 0; i < REG_COUNT; i++) begin
                    if (model_tag[i] == cdb_tag) begin
                        model_ready[i] = 1'b1;
                    end
                end
            end
            if (accept) begin
                rob_q.push_back({1'b0, dispatch_rd, {1'b0, model_tail}});
                if (dispatch_rd != ZERO_REG) begin
                    model_tag[dispatch_rd]   = {1'b0, model_tail};
                    model_ready[dispatch_rd] = 1'b0;
                end
                model_tail = model_tail + 1'b1;
            end
        end
    endtask

    task automatic advance();
        @(posedge clock);
        update_model();
        #1;
        dispatch_enable = 1'b0;
        cdb_valid       = 1'b0;
        squash          = 1'b0;
    endtask

    `include "rename_stage_tasks.svh"

    //////////////////////////////
    // run control
    //////////////////////////////

    initial begin
        void'($urandom(32'h58c2_3fd9));
        errors          = 0;
        checks          = 0;
        reset           = 1'b1;
        dispatch_enable = 1'b0;
        dispatch_rd     = '0;
        src1_reg        = '0;
        src2_reg        = '0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        squash          = 1'b0;
        clear_model();
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        check_clear_state();
        test_rename();
        test_wakeup();
        test_retire();
        test_full();
        test_squash();

        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // stops a hung run
    initial begin
        repeat (RUN_CYCLES + MARGIN) @(posedge clock);
        $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES + MARGIN);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_enable,
    input  rename_pkg::reg_idx_t dispatch_rd,
    input  rename_pkg::reg_idx_t src1_reg,
    input  rename_pkg::reg_idx_t src2_reg,
    input  logic                 cdb_valid,
    input  rename_pkg::tag_t     cdb_tag,
    input  logic                 squash,
    output rename_pkg::tag_t     dispatch_tag,
    output logic                 full,
    output rename_pkg::tag_t     src1_tag,
    output logic                 src1_ready,
    output rename_pkg::tag_t     src2_tag,
    output logic                 src2_ready,
    output logic                 retire_valid,
    output rename_pkg::reg_idx_t retire_reg,
    output rename_pkg::tag_t     retire_tag
);

    // dispatch that the buffer actually took
    logic dispatch_accept;

    //////////////////////////////
    // reorder buffer
    //////////////////////////////

    reorder_buffer u_rob (
        .clock           (clock),
        .reset           (reset),
        .dispatch_enable (dispatch_enable),
        .dispatch_rd     (dispatch_rd),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .squash          (squash),
        .dispatch_accept (dispatch_accept),
        .dispatch_tag    (dispatch_tag),
        .full            (full),
        .retire_valid    (retire_valid),
        .retire_reg      (retire_reg),
        .retire_tag      (retire_tag)
    );

    //////////////////////////////
    // map table
    //////////////////////////////

    // tail tag and head entry come straight from the buffer
    map_table u_map (
        .clock           (clock),
        .reset           (reset),
        .dispatch_accept (dispatch_accept),
        .dispatch_rd     (dispatch_rd),
        .dispatch_tag    (dispatch_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .retire_valid    (retire_valid),
        .retire_reg      (retire_reg),
        .retire_tag      (retire_tag),
        .squash          (squash),
        .src1_reg        (src1_reg),
        .src2_reg        (src2_reg),
        .src1_tag        (src1_tag),
        .src1_ready      (src1_ready),
        .src2_tag        (src2_tag),
        .src2_ready      (src2_ready)
    );

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_enable,
    input  rename_pkg::reg_idx_t dispatch_rd,
    input  logic                 cdb_valid,
    input  rename_pkg::tag_t     cdb_tag,
    input  logic                 squash,
    output logic                 dispatch_accept,
    output rename_pkg::tag_t     dispatch_tag,
    output logic                 full,
    output logic                 retire_valid,
    output rename_pkg::reg_idx_t retire_reg,
    output rename_pkg::tag_t     retire_tag
);

    import rename_pkg::*;

    // circular pointers and occupancy
    rob_idx_t             head;
    rob_idx_t             tail;
    logic [ROB_IDX_W:0]   count;

    // per-entry state
    reg_idx_t             dest_reg [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] complete;
    logic [ROB_DEPTH-1:0] occupied;

    // completion decode
    logic                 cdb_hit;
    rob_idx_t             cdb_idx;

    //////////////////////////////
    // occupancy and status
    //////////////////////////////

    // entry is live when it lies fewer than count slots past head
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            occupied[i] = ({1'b0, rob_idx_t'(rob_idx_t'(i) - head)} < count);
        end
    end

    assign full            = (count == (ROB_IDX_W + 1)'(ROB_DEPTH));
    assign dispatch_accept = dispatch_enable && !full;
    assign dispatch_tag    = {1'b0, tail};

    // in-flight tags only, register file tags never complete here
    assign cdb_hit = cdb_valid && !cdb_tag[TAG_W-1];
    assign cdb_idx = cdb_tag[ROB_IDX_W-1:0];

    // head leaves as soon as it is done
    assign retire_valid = occupied[head] && complete[head];
    assign retire_reg   = dest_reg[head];
    assign retire_tag   = {1'b0, head};

    //////////////////////////////
    // pointers
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch_accept) begin
                tail <= tail + 1'b1;
            end
            if (retire_valid) begin
                head <= head + 1'b1;
            end
            // dispatch and retire in one cycle leave count as is
            case ({dispatch_accept, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////
    // entry state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            complete <= '0;
        end else begin
            if (cdb_hit) begin
                complete[cdb_idx] <= 1'b1;
            end
            // fresh entry starts incomplete
            if (dispatch_accept) begin
                complete[tail] <= 1'b0;
            end
        end
    end

    // destination register payload
    always_ff @(posedge clock) begin
        if (dispatch_accept) begin
            dest_reg[tail] <= dispatch_rd;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // broadcast must name an entry that was dispatched and not yet retired
    cdb_names_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> (!cdb_tag[TAG_W-1] && occupied[cdb_idx])
    ) else $error("reorder_buffer: completion for tag %0h hits an empty entry", cdb_tag);

    // occupancy stays within the buffer across every update
    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        count <= (ROB_IDX_W + 1)'(ROB_DEPTH)
    ) else $error("reorder_buffer: count %0d above depth", count);

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps

module map_table (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_accept,
    input  rename_pkg::reg_idx_t dispatch_rd,
    input  rename_pkg::tag_t     dispatch_tag,
    input  logic                 cdb_valid,
    input  rename_pkg::tag_t     cdb_tag,
    input  logic                 retire_valid,
    input  rename_pkg::reg_idx_t retire_reg,
    input  rename_pkg::tag_t     retire_tag,
    input  logic                 squash,
    input  rename_pkg::reg_idx_t src1_reg,
    input  rename_pkg::reg_idx_t src2_reg,
    output rename_pkg::tag_t     src1_tag,
    output logic                 src1_ready,
    output rename_pkg::tag_t     src2_tag,
    output logic                 src2_ready
);

    import rename_pkg::*;

    // current mapping per architectural register
    tag_t                 map_tag   [REG_COUNT];
    logic [REG_COUNT-1:0] map_ready;

    // mapping after this cycle's updates
    tag_t                 tag_next  [REG_COUNT];
    logic [REG_COUNT-1:0] ready_next;

    logic                 retire_hit;
    logic                 cdb_live;
    logic                 rename_write;
    logic                 src1_bypass;
    logic                 src2_bypass;

    // retiring head still owns its register
    assign retire_hit   = retire_valid && (map_tag[retire_reg] == retire_tag);
    assign cdb_live     = cdb_valid && !cdb_tag[TAG_W-1];
    assign rename_write = dispatch_accept && (dispatch_rd != ZERO_REG);

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        tag_next   = map_tag;
        ready_next = map_ready;

        // retire clear first
        if (retire_hit) begin
            tag_next[retire_reg]   = ZERO_TAG;
            ready_next[retire_reg] = 1'b0;
        end

        // wake every register waiting on the broadcast tag
        if (cdb_live) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                if (tag_next[i] == cdb_tag) begin
                    ready_next[i] = 1'b1;
                end
            end
        end

        // newest producer wins
        if (rename_write) begin
            tag_next[dispatch_rd]   = dispatch_tag;
            ready_next[dispatch_rd] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            map_tag   <= '{default: ZERO_TAG};
            map_ready <= '0;
        end else begin
            map_tag   <= tag_next;
            map_ready <= ready_next;
        end
    end

    //////////////////////////////
    // source lookups
    //////////////////////////////

    // mapping cleared by this cycle's retire reads as register file
    assign src1_bypass = retire_hit && (retire_reg == src1_reg);
    assign src2_bypass = retire_hit && (retire_reg == src2_reg);

    always_comb begin
        if (src1_bypass) begin
            src1_tag   = ZERO_TAG;
            src1_ready = 1'b0;
        end else begin
            src1_tag   = map_tag[src1_reg];
            src1_ready = map_ready[src1_reg];
        end
    end

    always_comb begin
        if (src2_bypass) begin
            src2_tag   = ZERO_TAG;
            src2_ready = 1'b0;
        end else begin
            src2_tag   = map_tag[src2_reg];
            src2_ready = map_ready[src2_reg];
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // zero register never picks up a producer, through any update path
    zero_reg_unmapped: assert property (
        @(posedge clock) disable iff (reset)
        (map_tag[ZERO_REG] == ZERO_TAG) && !map_ready[ZERO_REG]
    ) else $error("map_table: register 0 mapped to tag %0h", map_tag[ZERO_REG]);

endmodule

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    // architectural registers
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // reorder buffer entries
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    // one extra bit above the buffer index
    localparam int TAG_W = ROB_IDX_W + 1;

    //////////////////////////////
    // types and constants
    //////////////////////////////

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;

    // top bit set means the value sits in the register file
    localparam tag_t ZERO_TAG = {1'b1, {ROB_IDX_W{1'b0}}};

    // hardwired zero register, never renamed
    localparam reg_idx_t ZERO_REG = '0;

endpackage
